//--- source/rv_pkg.sv
package rv_pkg;

  // datapath width, also the address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0]   word_t;     // register, address or instruction
  typedef logic [4:0]        reg_addr_t; // register index
  typedef logic [xlen/8-1:0] wmask_t;    // one enable per byte lane

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_load   = 7'b000_0011,
    op_imm    = 7'b001_0011,
    op_auipc  = 7'b001_0111,
    op_store  = 7'b010_0011,
    op_reg    = 7'b011_0011,
    op_lui    = 7'b011_0111,
    op_branch = 7'b110_0011,
    op_jalr   = 7'b110_0111,
    op_jal    = 7'b110_1111,
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 values overlap between formats, so these are plain constants
  typedef logic [2:0] funct3_e;

  // branch conditions
  localparam funct3_e beq  = 3'b000;
  localparam funct3_e bne  = 3'b001;
  localparam funct3_e blt  = 3'b100;
  localparam funct3_e bge  = 3'b101;
  localparam funct3_e bltu = 3'b110;
  localparam funct3_e bgeu = 3'b111;

  // load/store widths
  localparam funct3_e f3_byte   = 3'b000;
  localparam funct3_e f3_half   = 3'b001;
  localparam funct3_e f3_word   = 3'b010;
  localparam funct3_e f3_byte_u = 3'b100;
  localparam funct3_e f3_half_u = 3'b101;

  localparam funct3_e f3_add = 3'b000; // add, sub, addi, jalr, ebreak

  // source of the register write-back value
  typedef enum logic [1:0] {
    wb_alu      = 2'd0,
    wb_pc_plus4 = 2'd1,
    wb_load     = 2'd2
  } wb_sel_e;

endpackage

//--- source/rv_decoder.sv
module rv_decoder (
  input  rv_pkg::word_t     inst,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output logic [2:0]        funct3,
  output rv_pkg::word_t     imm,
  output logic              reg_write,
  output logic              mem_read,
  output logic              mem_write,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              op_a_pc,
  output logic              op_b_imm,
  output logic              sub,
  output logic              ebreak,
  output rv_pkg::wb_sel_e   wb_sel
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       load_ok;
  logic       store_ok;
  logic       branch_ok;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct7 = inst[31:25];
  assign funct3 = inst[14:12];
  assign rd     = inst[11:7];
  assign rs2    = inst[24:20];
  // lui has no rs1 field, reading x0 makes the adder pass the immediate
  assign rs1    = (opcode == op_lui) ? '0 : inst[19:15];

  // immediates, all sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign load_ok   = funct3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u};
  assign store_ok  = funct3 inside {f3_byte, f3_half, f3_word};
  assign branch_ok = funct3 inside {beq, bne, blt, bge, bltu, bgeu};

  always_comb begin
    // defaults: no side effects, sequential flow
    imm       = '0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    op_a_pc   = 1'b0;
    op_b_imm  = 1'b0;
    sub       = 1'b0;
    ebreak    = 1'b0;
    wb_sel    = wb_alu;
    case (opcode)
      op_imm: begin
        imm       = imm_i;
        op_b_imm  = 1'b1;
        reg_write = (funct3 == f3_add); // only addi
      end
      op_reg: begin
        if (funct3 == f3_add && funct7 == 7'b000_0000) begin
          reg_write = 1'b1;
        end else if (funct3 == f3_add && funct7 == 7'b010_0000) begin
          reg_write = 1'b1;
          sub       = 1'b1;
        end
      end
      op_lui: begin
        imm       = imm_u;
        op_b_imm  = 1'b1;
        reg_write = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        op_a_pc   = 1'b1;
        op_b_imm  = 1'b1;
        reg_write = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        op_a_pc   = 1'b1;
        op_b_imm  = 1'b1;
        is_jal    = 1'b1;
        reg_write = 1'b1;
        wb_sel    = wb_pc_plus4; // link
      end
      op_jalr: begin
        imm       = imm_i;
        op_b_imm  = 1'b1;
        is_jalr   = (funct3 == f3_add);
        reg_write = (funct3 == f3_add);
        wb_sel    = wb_pc_plus4;
      end
      op_branch: begin
        imm       = imm_b;
        op_a_pc   = 1'b1; // adder forms the target
        op_b_imm  = 1'b1;
        is_branch = branch_ok;
      end
      op_load: begin
        imm       = imm_i;
        op_b_imm  = 1'b1;
        mem_read  = load_ok;
        reg_write = load_ok;
        wb_sel    = wb_load;
      end
      op_store: begin
        imm       = imm_s;
        op_b_imm  = 1'b1;
        mem_write = store_ok;
      end
      op_system: begin
        ebreak = (inst[31:20] == 12'h001) && (inst[19:7] == '0);
      end
      default: ;
    endcase
  end

endmodule

//--- source/rv_regfile.sv
module rv_regfile #(
  parameter int nr_regs = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              wen,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2
);
  import rv_pkg::*;

  word_t regs [nr_regs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < nr_regs; i++) regs[i] <= '0;
    end else if (wen && waddr != '0 && int'(waddr) < nr_regs) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 and indices past the last register read as zero
  assign rdata1 = (raddr1 == '0 || int'(raddr1) >= nr_regs) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0 || int'(raddr2) >= nr_regs) ? '0 : regs[raddr2];

endmodule

//--- source/rv_execute.sv
module rv_execute (
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  logic          op_a_pc,
  input  logic          op_b_imm,
  input  logic          sub,
  input  logic          is_branch,
  input  logic          is_jal,
  input  logic          is_jalr,
  input  logic [2:0]    funct3,
  output rv_pkg::word_t alu_result,
  output rv_pkg::word_t pc_plus4,
  output rv_pkg::word_t next_pc
);
  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t op_b_inv;
  logic  eq;
  logic  lt;
  logic  ltu;
  logic  taken;

  assign op_a = op_a_pc  ? pc  : rs1_data;
  assign op_b = op_b_imm ? imm : rs2_data;

  // single adder, subtract as a + ~b + 1
  assign op_b_inv   = op_b ^ {xlen{sub}};
  assign alu_result = op_a + op_b_inv + word_t'(sub);

  assign pc_plus4 = pc + word_t'(4);

  // branch compare works on the registers, the adder is busy with the target
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      beq:     taken = eq;
      bne:     taken = ~eq;
      blt:     taken = lt;
      bge:     taken = ~lt;
      bltu:    taken = ltu;
      bgeu:    taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jal) begin
      next_pc = alu_result;
    end else if (is_jalr) begin
      next_pc = {alu_result[xlen-1:1], 1'b0}; // jalr drops bit 0
    end else if (is_branch && taken) begin
      next_pc = alu_result;
    end else begin
      next_pc = pc_plus4;
    end
  end

endmodule

//--- source/rv_lsu.sv
module rv_lsu (
  input  rv_pkg::word_t  addr,
  input  rv_pkg::word_t  store_data,
  input  rv_pkg::word_t  mem_rdata,
  input  logic [2:0]     funct3,
  output rv_pkg::word_t  mem_wdata,
  output rv_pkg::wmask_t mem_wmask,
  output rv_pkg::word_t  load_data
);
  import rv_pkg::*;

  logic [1:0]  lane;
  logic        half_ok;
  logic        word_ok;
  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  assign lane    = addr[1:0];
  assign half_ok = ~addr[0];      // halfword on a 2-byte boundary
  assign word_ok = (lane == 2'b00);

  // store side: replicate across lanes, the mask picks the live ones
  always_comb begin
    mem_wdata = store_data;
    mem_wmask = '0;
    case (funct3)
      f3_byte: begin
        mem_wdata = {4{store_data[7:0]}};
        mem_wmask = wmask_t'(4'b0001 << lane);
      end
      f3_half: begin
        mem_wdata = {2{store_data[15:0]}};
        if (half_ok) mem_wmask = wmask_t'(4'b0011 << lane);
      end
      f3_word: begin
        if (word_ok) mem_wmask = '1;
      end
      default: ;
    endcase
  end

  // load side
  assign byte_lane = mem_rdata[8*lane +: 8];
  assign half_lane = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    load_data = '0; // misaligned or unknown width
    case (funct3)
      f3_byte: begin
        load_data = {{(xlen-8){byte_lane[7]}}, byte_lane};
      end
      f3_byte_u: begin
        load_data = {{(xlen-8){1'b0}}, byte_lane};
      end
      f3_half: begin
        if (half_ok) load_data = {{(xlen-16){half_lane[15]}}, half_lane};
      end
      f3_half_u: begin
        if (half_ok) load_data = {{(xlen-16){1'b0}}, half_lane};
      end
      f3_word: begin
        if (word_ok) load_data = mem_rdata;
      end
      default: ;
    endcase
  end

endmodule

//--- source/rv_core.sv
module rv_core #(
  parameter rv_pkg::word_t reset_vector = 32'h8000_0000,
  parameter int            nr_regs      = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  rv_pkg::word_t  inst,
  input  rv_pkg::word_t  mem_rdata,
  output rv_pkg::word_t  pc,
  output rv_pkg::word_t  mem_addr,
  output rv_pkg::word_t  mem_wdata,
  output rv_pkg::wmask_t mem_wmask,
  output logic           mem_read,
  output logic           mem_write,
  output logic           halt
);
  import rv_pkg::*;

  // decode
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  logic [2:0] funct3;
  word_t      imm;
  logic       reg_write;
  logic       dec_mem_read;
  logic       dec_mem_write;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic       op_a_pc;
  logic       op_b_imm;
  logic       sub;
  logic       ebreak;
  wb_sel_e    wb_sel;

  // datapath
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t pc_plus4;
  word_t next_pc;
  word_t load_data;
  word_t wb_data;
  logic  halted;

  rv_decoder u_decoder (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .imm       (imm),
    .reg_write (reg_write),
    .mem_read  (dec_mem_read),
    .mem_write (dec_mem_write),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .op_a_pc   (op_a_pc),
    .op_b_imm  (op_b_imm),
    .sub       (sub),
    .ebreak    (ebreak),
    .wb_sel    (wb_sel)
  );

  rv_regfile #(
    .nr_regs (nr_regs)
  ) u_regfile (
    .clk    (clk),
    .reset  (reset),
    .wen    (reg_write & ~halt),
    .waddr  (rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_execute u_execute (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .op_a_pc    (op_a_pc),
    .op_b_imm   (op_b_imm),
    .sub        (sub),
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .funct3     (funct3),
    .alu_result (alu_result),
    .pc_plus4   (pc_plus4),
    .next_pc    (next_pc)
  );

  rv_lsu u_lsu (
    .addr       (alu_result),
    .store_data (rs2_data),
    .mem_rdata  (mem_rdata),
    .funct3     (funct3),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .load_data  (load_data)
  );

  always_comb begin
    case (wb_sel)
      wb_pc_plus4: wb_data = pc_plus4; // jal/jalr link
      wb_load:     wb_data = load_data;
      default:     wb_data = alu_result;
    endcase
  end

  // halt goes high already in the ebreak cycle
  assign halt      = halted | ebreak;
  assign mem_addr  = alu_result;
  assign mem_read  = dec_mem_read;
  assign mem_write = dec_mem_write & ~halt & ~reset; // no stray store during reset

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= reset_vector;
      halted <= 1'b0;
    end else begin
      if (!halt) pc <= next_pc; // pc parks on the ebreak
      if (ebreak) halted <= 1'b1;
    end
  end

endmodule

//--- verif/rv_core_tests.svh
`ifndef rv_core_tests_svh
`define rv_core_tests_svh

localparam int    n_tests = 10;
localparam word_t ebrk    = 32'h0010_0073;

// program words, index 0 is fetched at the reset vector
logic [0:11][31:0] prog [n_tests];
word_t pre_addr [n_tests];  // preloaded data word
word_t pre_data [n_tests];
word_t chk_addr [n_tests];  // word read back after halt
word_t exp_word [n_tests];
word_t exp_pc   [n_tests];  // address of the ebreak

task automatic set_row(input int t, input word_t p_addr, input word_t p_data,
                       input word_t c_addr, input word_t c_word, input word_t f_pc);
  pre_addr[t] = p_addr;
  pre_data[t] = p_data;
  chk_addr[t] = c_addr;
  exp_word[t] = c_word;
  exp_pc[t]   = f_pc;
endtask

task automatic build_table();
  // addi 100, addi -7, add, sub, lui, add, sub, sw
  prog[0] = {32'h0640_0093, 32'hff90_0113, 32'h0020_81b3, 32'h4020_8233,
             32'h1234_52b7, 32'h0042_8333, 32'h4033_0333, 32'h0460_2023,
             ebrk, ebrk, ebrk, ebrk};
  set_row(0, 32'h40, 32'h0, 32'h40, 32'h1234_500e, 32'h8000_0020);
  // auipc at +4 and +8, difference plus one
  prog[1] = {32'h0010_0093, 32'h0001_2117, 32'hffff_f197, 32'h4031_0233,
             32'h0012_0233, 32'h0440_2223, ebrk, ebrk,
             ebrk, ebrk, ebrk, ebrk};
  set_row(1, 32'h44, 32'h0, 32'h44, 32'h0001_2ffd, 32'h8000_0018);
  // x1 = -1, x2 = 1; beq no, bne yes (2), blt yes (4)
  prog[2] = {32'hfff0_0093, 32'h0010_0113, 32'h0020_8463, 32'h0080_006f,
             32'h0011_8193, 32'h0020_9463, 32'h0080_006f, 32'h0021_8193,
             32'h0020_c463, 32'h0080_006f, 32'h0041_8193, 32'h0430_2423};
  set_row(2, 32'h48, 32'h0, 32'h48, 32'h0000_0006, 32'h8000_0030);
  // bge x2,x1 yes (1), bltu x1,x2 no, bgeu x1,x2 yes (4)
  prog[3] = {32'hfff0_0093, 32'h0010_0113, 32'h0011_5463, 32'h0080_006f,
             32'h0011_8193, 32'h0020_e463, 32'h0080_006f, 32'h0021_8193,
             32'h0020_f463, 32'h0080_006f, 32'h0041_8193, 32'h0430_2423};
  set_row(3, 32'h48, 32'h0, 32'h48, 32'h0000_0005, 32'h8000_0030);
  // jal to +12, jalr to an odd target, skipped slots bump x5
  prog[4] = {32'h00c0_00ef, 32'h0010_0293, 32'h0010_0293, 32'h0150_83e7,
             32'h0010_0293, 32'h0010_0293, 32'h0053_8433, 32'h0480_2623,
             ebrk, ebrk, ebrk, ebrk};
  set_row(4, 32'h4c, 32'h0, 32'h4c, 32'h8000_0010, 32'h8000_0020);
  // sh lane 0, sb lane 1, sb lane 3
  prog[5] = {32'h0abc_d0b7, 32'h7ef0_8093, 32'h05a0_0113, 32'h0410_1823,
             32'h0410_08a3, 32'h0420_09a3, ebrk, ebrk,
             ebrk, ebrk, ebrk, ebrk};
  set_row(5, 32'h50, 32'h1122_3344, 32'h50, 32'h5a22_efef, 32'h8000_0018);
  // sh lane 2, sb lane 2, sb lane 0
  prog[6] = {32'h0abc_d0b7, 32'h7ef0_8093, 32'h05a0_0113, 32'h07c0_0193,
             32'h0410_1b23, 32'h0420_0b23, 32'h0430_0a23, ebrk,
             ebrk, ebrk, ebrk, ebrk};
  set_row(6, 32'h54, 32'h1122_3344, 32'h54, 32'hd75a_337c, 32'h8000_001c);
  // lb from all lanes and lh from both halves, summed
  prog[7] = {32'h0600_0083, 32'h0610_0103, 32'h0020_81b3, 32'h0620_0083,
             32'h0011_81b3, 32'h0630_0083, 32'h0011_81b3, 32'h0600_1083,
             32'h0011_81b3, 32'h0620_1083, 32'h0011_81b3, 32'h0630_2223};
  set_row(7, 32'h60, 32'h80f1_7f92, 32'h64, 32'h0000_0005, 32'h8000_0030);
  // same with lbu and lhu
  prog[8] = {32'h0600_4083, 32'h0610_4103, 32'h0020_81b3, 32'h0620_4083,
             32'h0011_81b3, 32'h0630_4083, 32'h0011_81b3, 32'h0600_5083,
             32'h0011_81b3, 32'h0620_5083, 32'h0011_81b3, 32'h0630_2223};
  set_row(8, 32'h60, 32'h80f1_7f92, 32'h64, 32'h0001_0305, 32'h8000_0030);
  // store right behind the ebreak must never happen
  prog[9] = {32'h1230_0093, ebrk, 32'h0610_2423, ebrk,
             ebrk, ebrk, ebrk, ebrk,
             ebrk, ebrk, ebrk, ebrk};
  set_row(9, 32'h68, 32'h0bad_f00d, 32'h68, 32'h0bad_f00d, 32'h8000_0004);
endtask

`endif

//--- verif/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam word_t reset_vector = 32'h8000_0000;

  logic   clk;
  logic   reset;
  word_t  inst;
  word_t  mem_rdata;
  word_t  pc;
  word_t  mem_addr;
  word_t  mem_wdata;
  wmask_t mem_wmask;
  logic   mem_read;
  logic   mem_write;
  logic   halt;

  `include "rv_core_tests.svh"

  // two cycles per program slot plus reset
  localparam int timeout_cycles = n_tests * 12 * 2 + n_tests * 2;

  word_t       imem [16];
  word_t       dmem [64]; // byte address bits 7:2
  word_t       pc_offset;
  logic [15:0] lfsr_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycles;

  rv_core #(
    .reset_vector (reset_vector),
    .nr_regs      (32)
  ) dut0 (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fetch past the program reads ebreak
  assign pc_offset = pc - reset_vector;
  assign inst      = (pc_offset < 32'd64) ? imem[pc_offset[5:2]] : ebrk;
  assign mem_rdata = mem_read ? dmem[mem_addr[7:2]] : '0;

  function automatic word_t merge_bytes(word_t old_word, word_t new_word, wmask_t mask);
    word_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) w[8*b +: 8] = new_word[8*b +: 8];
    end
    return w;
  endfunction

  always @(posedge clk) begin
    if (mem_write === 1'b1) begin
      dmem[mem_addr[7:2]] <= merge_bytes(dmem[mem_addr[7:2]], mem_wdata, mem_wmask);
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic fill_background();
    word_t w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      for (int b = 0; b < 32; b++) begin
        w = {w[30:0], lfsr_state[15]};
        lfsr_state = lfsr_next(lfsr_state);
      end
      dmem[i] = w;
    end
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic run_test(int t);
    int errors_before;
    errors_before = errors;
    @(posedge clk);
    #1;
    reset = 1'b1;
    for (int i = 0; i < 16; i++) begin
      imem[i] = (i < 12) ? prog[t][i] : ebrk;
    end
    fill_background(); // old contents gone
    dmem[pre_addr[t][7:2]] = pre_data[t];
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    while (!halt) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk); // halt flag latched here
    #1;
    // only the halt flag now keeps the following word from running
    imem[pc_offset[5:2]] = imem[pc_offset[5:2] + 1];
    repeat (2) @(posedge clk); // pc should stay parked
    #1;
    check_word($sformatf("test %0d data word", t), dmem[chk_addr[t][7:2]], exp_word[t]);
    check_word($sformatf("test %0d final pc", t), pc, exp_pc[t]);
    check_word($sformatf("test %0d halt", t), halt, 32'd1);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %0d passed", t);
    end else begin
      tests_failed++;
      $display("test %0d failed", t);
    end
  endtask

  initial begin
    reset        = 1'b1;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr_state   = 16'd50;
    for (int i = 0; i < 16; i++) begin
      imem[i] = ebrk;
    end
    fill_background();
    build_table();
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the core did not halt within %0d cycles", timeout_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+verif
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_lsu.sv
source/rv_core.sv
verif/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_execute.sv
  - source/rv_lsu.sv
  - source/rv_core.sv
  - target: verif
    include_dirs:
      - verif
    files:
      - verif/rv_core_tb.sv
